/* common/rob_macros.svh */
// sizing constants for the two-wide reorder buffer
// ROB_ENTRIES must equal 2**ROB_TAG_BITS, since head and tail wrap by overflow
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// buffer geometry
`define ROB_ENTRIES   16
`define ROB_TAG_BITS  4

// datapath widths
`define REG_BITS      5
`define VALUE_BITS    32

// destination shown on a retire port that is idle
`define ZERO_REG      31

`endif

/* common/rob_pkg.sv */
// types shared by all reorder buffer blocks
// widths come from rob_macros.svh
`include "rob_macros.svh"

package rob_pkg;

  typedef logic [`ROB_TAG_BITS-1:0] rob_tag_t;
  typedef logic [`REG_BITS-1:0]     reg_idx_t;
  typedef logic [`VALUE_BITS-1:0]   value_t;

  // lifetime of one buffer slot
  typedef enum logic [1:0] {
    EMPTY    = 2'b00,
    IN_USE   = 2'b01,
    COMPLETE = 2'b10
  } entry_state_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t dest;
  } dispatch_t;

  // one common data bus beat, valid marks a live broadcast
  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    value_t   value;
    logic     mispredicted;
  } cdb_t;

  typedef struct packed {
    entry_state_t state;
    reg_idx_t     dest;
    value_t       value;
    logic         mispredicted;
  } entry_view_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    reg_idx_t dest;
    value_t   value;
    logic     mispredicted;
  } retire_t;

endpackage

/* rob_entry_file/rob_entry.sv */
// one reorder buffer slot with its own CDB tag compare
// a dispatch write wins over a CDB match, cdb1 wins over cdb2
`timescale 1ns/1ps

module rob_entry
  import rob_pkg::*;
#(
  parameter rob_tag_t ENTRY_TAG = '0
)
(
  input  logic        clock,
  input  logic        reset,
  input  logic        write,
  input  reg_idx_t    dest_in,
  input  cdb_t        cdb1,
  input  cdb_t        cdb2,
  output entry_view_t view
);

  entry_state_t state;
  entry_state_t state_next;
  reg_idx_t     dest;
  value_t       value;
  logic         mispredicted;
  logic         cdb1_match;
  logic         cdb2_match;

  // only a slot waiting on its result listens to the buses
  assign cdb1_match = (state == IN_USE) && cdb1.valid && (cdb1.tag == ENTRY_TAG);
  assign cdb2_match = (state == IN_USE) && cdb2.valid && (cdb2.tag == ENTRY_TAG);

  always_comb
  begin
    state_next = state;
    if (write)
      state_next = IN_USE;
    else if (cdb1_match || cdb2_match)
      state_next = COMPLETE;
  end

  // reset here also carries the retire free strobe
  always_ff @(posedge clock)
  begin
    if (reset)
      state <= EMPTY;
    else
      state <= state_next;
  end

  always_ff @(posedge clock)
  begin
    if (write)
      dest <= dest_in;
    else if (cdb1_match)
    begin
      value        <= cdb1.value;
      mispredicted <= cdb1.mispredicted;
    end
    else if (cdb2_match)
    begin
      value        <= cdb2.value;
      mispredicted <= cdb2.mispredicted;
    end
  end

  assign view = '{state: state, dest: dest, value: value, mispredicted: mispredicted};

endmodule

/* rob_entry_file/rob_entry_file.sv */
// array of reorder buffer slots, indexed by tag
// each slot is cleared by the global reset or by its retire free strobe
// rob_empty is high only when every slot is EMPTY
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_entry_file
  import rob_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  logic [`ROB_ENTRIES-1:0] write_en,
  input  reg_idx_t                write_dest [`ROB_ENTRIES],
  input  logic [`ROB_ENTRIES-1:0] free_en,
  input  cdb_t                    cdb1,
  input  cdb_t                    cdb2,
  output entry_view_t             views      [`ROB_ENTRIES],
  output logic [`ROB_ENTRIES-1:0] empty_mask,
  output logic                    rob_empty
);

  logic [`ROB_ENTRIES-1:0] entry_reset;

  //////////////////////////////////////////////////////////////////////
  // slot instances
  //////////////////////////////////////////////////////////////////////
  genvar i;
  generate
    for (i = 0; i < `ROB_ENTRIES; i++)
    begin : g_entry
      // free and reset both return the slot to EMPTY
      assign entry_reset[i] = reset || free_en[i];

      rob_entry #(
        .ENTRY_TAG (rob_tag_t'(i))
      ) u_entry (
        .clock   (clock),
        .reset   (entry_reset[i]),
        .write   (write_en[i]),
        .dest_in (write_dest[i]),
        .cdb1    (cdb1),
        .cdb2    (cdb2),
        .view    (views[i])
      );

      assign empty_mask[i] = (views[i].state == EMPTY);
    end
  endgenerate

  //////////////////////////////////////////////////////////////////////
  // occupancy
  //////////////////////////////////////////////////////////////////////
  assign rob_empty = &empty_mask;

endmodule

/* design/rob_dispatch.sv */
// tail side of the reorder buffer
// both slots ahead of the tail must be EMPTY or nothing is taken this cycle
// tags and write strobes are combinational, the tail moves at the edge
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_dispatch
  import rob_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  dispatch_t               dispatch1,
  input  dispatch_t               dispatch2,
  input  logic [`ROB_ENTRIES-1:0] empty_mask,
  output logic [`ROB_ENTRIES-1:0] write_en,
  output reg_idx_t                write_dest [`ROB_ENTRIES],
  output rob_tag_t                tag1,
  output rob_tag_t                tag2,
  output logic                    tag1_valid,
  output logic                    tag2_valid,
  output logic                    rob_full
);

  rob_tag_t tail;
  rob_tag_t tail_plus_one;
  logic     accept1;
  logic     accept2;

  assign tail_plus_one = tail + rob_tag_t'(1);
  assign rob_full      = !(empty_mask[tail] && empty_mask[tail_plus_one]);

  assign accept1 = dispatch1.valid && !rob_full;
  assign accept2 = dispatch2.valid && !rob_full;

  // lowest valid input takes the tail slot
  assign tag1       = tail;
  assign tag2       = accept1 ? tail_plus_one : tail;
  assign tag1_valid = accept1;
  assign tag2_valid = accept2;

  // when only dispatch2 is accepted tag1 equals tag2, so the first arm falls through
  always_comb
  begin
    for (int i = 0; i < `ROB_ENTRIES; i++)
    begin
      write_en[i]   = 1'b0;
      write_dest[i] = reg_idx_t'(`ZERO_REG);
      if (accept1 && (rob_tag_t'(i) == tag1))
      begin
        write_en[i]   = 1'b1;
        write_dest[i] = dispatch1.dest;
      end
      else if (accept2 && (rob_tag_t'(i) == tag2))
      begin
        write_en[i]   = 1'b1;
        write_dest[i] = dispatch2.dest;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      tail <= '0;
    else
      tail <= tail + rob_tag_t'(accept1) + rob_tag_t'(accept2);
  end

endmodule

/* design/rob_retire.sv */
// head side of the reorder buffer
// a second instruction retires only when neither head entry is mispredicted
// idle retire ports show ZERO_REG and zero fields
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_retire
  import rob_pkg::*;
(
  input  logic                    clock,
  input  logic                    reset,
  input  entry_view_t             views [`ROB_ENTRIES],
  output retire_t                 retire1,
  output retire_t                 retire2,
  output logic [`ROB_ENTRIES-1:0] free_en
);

  rob_tag_t    head;
  rob_tag_t    head_plus_one;
  entry_view_t head_view;
  entry_view_t next_view;
  logic        retire_one;
  logic        retire_two;

  // build one retire port, blank unless it fires
  function automatic retire_t make_retire(logic fire, rob_tag_t tag, entry_view_t view);
    retire_t r;
    r.valid        = 1'b0;
    r.tag          = '0;
    r.dest         = reg_idx_t'(`ZERO_REG);
    r.value        = '0;
    r.mispredicted = 1'b0;
    if (fire)
    begin
      r.valid        = 1'b1;
      r.tag          = tag;
      r.dest         = view.dest;
      r.value        = view.value;
      r.mispredicted = view.mispredicted;
    end
    return r;
  endfunction

  assign head_plus_one = head + rob_tag_t'(1);
  assign head_view     = views[head];
  assign next_view     = views[head_plus_one];

  //////////////////////////////////////////////////////////////////////
  // retire selection
  //////////////////////////////////////////////////////////////////////
  assign retire_one = (head_view.state == COMPLETE);
  assign retire_two = retire_one && (next_view.state == COMPLETE) &&
                      !head_view.mispredicted && !next_view.mispredicted;

  assign retire1 = make_retire(retire_one, head, head_view);
  assign retire2 = make_retire(retire_two, head_plus_one, next_view);

  // retired slots go back to EMPTY at the edge
  always_comb
  begin
    for (int i = 0; i < `ROB_ENTRIES; i++)
      free_en[i] = (retire_one && (rob_tag_t'(i) == head)) ||
                   (retire_two && (rob_tag_t'(i) == head_plus_one));
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      head <= '0;
    else
      head <= head + rob_tag_t'(retire_one) + rob_tag_t'(retire_two);
  end

endmodule

/* design/rob_top.sv */
// two-wide reorder buffer top level
// dispatch is refused as a whole while rob_full is high, the source must retry
// retire outputs are combinational off the entry state
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_top
  import rob_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  dispatch_t dispatch1,
  input  dispatch_t dispatch2,
  input  cdb_t      cdb1,
  input  cdb_t      cdb2,
  output rob_tag_t  tag1,
  output rob_tag_t  tag2,
  output logic      tag1_valid,
  output logic      tag2_valid,
  output retire_t   retire1,
  output retire_t   retire2,
  output logic      rob_full,
  output logic      rob_empty
);

  logic [`ROB_ENTRIES-1:0] empty_mask;
  logic [`ROB_ENTRIES-1:0] write_en;
  logic [`ROB_ENTRIES-1:0] free_en;
  reg_idx_t                write_dest [`ROB_ENTRIES];
  entry_view_t             views      [`ROB_ENTRIES];

  // allocation at the tail
  rob_dispatch u_dispatch (
    .clock      (clock),
    .reset      (reset),
    .dispatch1  (dispatch1),
    .dispatch2  (dispatch2),
    .empty_mask (empty_mask),
    .write_en   (write_en),
    .write_dest (write_dest),
    .tag1       (tag1),
    .tag2       (tag2),
    .tag1_valid (tag1_valid),
    .tag2_valid (tag2_valid),
    .rob_full   (rob_full)
  );

  // in-order retirement at the head
  rob_retire u_retire (
    .clock   (clock),
    .reset   (reset),
    .views   (views),
    .retire1 (retire1),
    .retire2 (retire2),
    .free_en (free_en)
  );

  rob_entry_file u_entry_file (
    .clock      (clock),
    .reset      (reset),
    .write_en   (write_en),
    .write_dest (write_dest),
    .free_en    (free_en),
    .cdb1       (cdb1),
    .cdb2       (cdb2),
    .views      (views),
    .empty_mask (empty_mask),
    .rob_empty  (rob_empty)
  );

endmodule

/* verif/rob_asserts.sv */
// concurrent checks on reorder buffer internals, bound into rob_top
// all checks are idle while reset is high
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_asserts
  import rob_pkg::*;
(
  input logic                    clock,
  input logic                    reset,
  input logic [`ROB_ENTRIES-1:0] write_en,
  input logic [`ROB_ENTRIES-1:0] empty_mask,
  input logic                    rob_full,
  input retire_t                 retire1,
  input retire_t                 retire2
);

  // running count of failed checks
  int failures = 0;

  retire_in_order: assert property (@(posedge clock) disable iff (reset)
      retire2.valid |-> retire1.valid)
    else
    begin
      $error("retire2 valid while retire1 is idle");
      failures++;
    end

  // a dispatch write may only land on an EMPTY slot
  write_to_empty: assert property (@(posedge clock) disable iff (reset)
      (write_en & ~empty_mask) == '0)
    else
    begin
      $error("write strobe on a slot that is not EMPTY");
      failures++;
    end

  full_blocks_write: assert property (@(posedge clock) disable iff (reset)
      rob_full |-> (write_en == '0))
    else
    begin
      $error("write strobe while rob_full is high");
      failures++;
    end

endmodule

bind rob_top rob_asserts u_asserts (
  .clock      (clock),
  .reset      (reset),
  .write_en   (write_en),
  .empty_mask (empty_mask),
  .rob_full   (rob_full),
  .retire1    (retire1),
  .retire2    (retire2)
);

/* verif/rob_tb.sv */
// testbench for the two-wide reorder buffer
// a circular reference model tracks head, tail and each slot's result
// inputs change 2 ns after the rising edge, outputs are compared at the falling edge
`timescale 1ns/1ps
`include "rob_macros.svh"

module rob_tb
  import rob_pkg::*;
();

  localparam dispatch_t no_dispatch = '0;
  localparam cdb_t      no_cdb      = '0;

  logic      clock;
  logic      reset;
  dispatch_t dispatch1;
  dispatch_t dispatch2;
  cdb_t      cdb1;
  cdb_t      cdb2;
  rob_tag_t  tag1;
  rob_tag_t  tag2;
  logic      tag1_valid;
  logic      tag2_valid;
  retire_t   retire1;
  retire_t   retire2;
  logic      rob_full;
  logic      rob_empty;

  // reference model, indexed by tag
  reg_idx_t  m_dest  [`ROB_ENTRIES];
  value_t    m_value [`ROB_ENTRIES];
  logic      m_done  [`ROB_ENTRIES];
  logic      m_misp  [`ROB_ENTRIES];
  rob_tag_t  m_head;
  rob_tag_t  m_tail;
  int        m_count;

  int        errors       = 0;
  int        dual_retires = 0;
  int        misp_retires = 0;
  integer    seed         = 32'h5f4c_99c0;

  rob_top UUT (.*);

  initial
  begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // slot is between head and tail and still waits for its result
  function automatic logic in_use(rob_tag_t t);
    return (int'(rob_tag_t'(t - m_head)) < m_count) && !m_done[t];
  endfunction

  // second port fires only behind a first one, with no misprediction on either
  function automatic retire_t expected_retire(logic second);
    rob_tag_t t;
    logic     first_ok;
    logic     fire;
    t        = second ? m_head + rob_tag_t'(1) : m_head;
    first_ok = (m_count > 0) && m_done[m_head];
    if (second)
      fire = first_ok && (m_count > 1) && m_done[t] && !m_misp[m_head] && !m_misp[t];
    else
      fire = first_ok;
    if (fire)
      return '{valid: 1'b1, tag: t, dest: m_dest[t], value: m_value[t],
               mispredicted: m_misp[t]};
    return '{valid: 1'b0, tag: '0, dest: reg_idx_t'(`ZERO_REG), value: '0,
             mispredicted: 1'b0};
  endfunction

  task automatic model_push(reg_idx_t dest);
    m_dest[m_tail] = dest;
    m_done[m_tail] = 1'b0;
    m_tail         = m_tail + rob_tag_t'(1);
    m_count        = m_count + 1;
  endtask

  task automatic model_complete(cdb_t c);
    if (c.valid && in_use(c.tag))
    begin
      m_done[c.tag]  = 1'b1;
      m_value[c.tag] = c.value;
      m_misp[c.tag]  = c.mispredicted;
    end
  endtask

  task automatic report_fail(string what, logic [63:0] got, logic [63:0] want);
    errors++;
    $display("[FAIL] %0d ns: %s got %h expected %h", $time, what, got, want);
  endtask

  // compare, then advance the model past the coming rising edge
  always @(negedge clock)
  begin : compare
    retire_t  exp1;
    retire_t  exp2;
    rob_tag_t exp_tag2;
    logic     full;
    logic     exp_tv1;
    logic     exp_tv2;
    if (reset)
    begin
      m_head  = '0;
      m_tail  = '0;
      m_count = 0;
    end
    else
    begin
      full     = (m_count >= `ROB_ENTRIES - 1);
      exp1     = expected_retire(1'b0);
      exp2     = expected_retire(1'b1);
      exp_tv1  = dispatch1.valid && !full;
      exp_tv2  = dispatch2.valid && !full;
      exp_tag2 = dispatch1.valid ? m_tail + rob_tag_t'(1) : m_tail;
      assert (retire1 === exp1) else report_fail("retire1", 64'(retire1), 64'(exp1));
      assert (retire2 === exp2) else report_fail("retire2", 64'(retire2), 64'(exp2));
      assert (rob_full === full) else report_fail("rob_full", 64'(rob_full), 64'(full));
      assert (rob_empty === (m_count == 0))
        else report_fail("rob_empty", 64'(rob_empty), 64'(m_count == 0));
      assert (tag1_valid === exp_tv1)
        else report_fail("tag1_valid", 64'(tag1_valid), 64'(exp_tv1));
      assert (tag2_valid === exp_tv2)
        else report_fail("tag2_valid", 64'(tag2_valid), 64'(exp_tv2));
      assert (!exp_tv1 || tag1 === m_tail) else report_fail("tag1", 64'(tag1), 64'(m_tail));
      assert (!exp_tv2 || tag2 === exp_tag2)
        else report_fail("tag2", 64'(tag2), 64'(exp_tag2));
      if (retire2.valid === 1'b1)
        dual_retires++;
      if (retire1.valid === 1'b1 && retire1.mispredicted === 1'b1)
        misp_retires++;
      repeat (int'(exp1.valid) + int'(exp2.valid))
      begin
        m_head  = m_head + rob_tag_t'(1);
        m_count = m_count - 1;
      end
      // cdb1 goes first, so a shared tag is no longer waiting for cdb2
      model_complete(cdb1);
      model_complete(cdb2);
      if (!full && dispatch1.valid)
        model_push(dispatch1.dest);
      if (!full && dispatch2.valid)
        model_push(dispatch2.dest);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic dispatch_t random_op();
    return '{valid: 1'b1, dest: reg_idx_t'($random(seed))};
  endfunction

  function automatic cdb_t result_for(rob_tag_t t, logic misp);
    return '{valid: 1'b1, tag: t, value: value_t'($random(seed)), mispredicted: misp};
  endfunction

  task automatic drive(dispatch_t d1, dispatch_t d2, cdb_t c1, cdb_t c2);
    dispatch1 = d1;
    dispatch2 = d2;
    cdb1      = c1;
    cdb2      = c2;
    @(posedge clock);
    #2;
  endtask

  task automatic give_up(string what);
    $display("timeout: %s", what);
    $display("TESTS FAILED");
    $finish;
  endtask

  // finish waiting slots youngest first, two per cycle, until the buffer is empty
  task automatic drain(int limit);
    int   cycles;
    cdb_t c1;
    cdb_t c2;
    cycles = 0;
    while (m_count != 0 && cycles < limit)
    begin
      c1 = no_cdb;
      c2 = no_cdb;
      for (int k = `ROB_ENTRIES - 1; k >= 0; k--)
      begin
        if (in_use(m_head + rob_tag_t'(k)) && !c1.valid)
          c1 = result_for(m_head + rob_tag_t'(k), 1'b0);
        else if (in_use(m_head + rob_tag_t'(k)) && !c2.valid)
          c2 = result_for(m_head + rob_tag_t'(k), 1'b0);
      end
      drive(no_dispatch, no_dispatch, c1, c2);
      cycles++;
    end
    if (m_count != 0)
      give_up("buffer did not drain in time");
  endtask

  task automatic end_test(string name, int mark);
    if (errors == mark)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - mark);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial
  begin
    int       mark;
    int       dual_mark;
    int       misp_mark;
    rob_tag_t base;
    reset     = 1'b1;
    dispatch1 = no_dispatch;
    dispatch2 = no_dispatch;
    cdb1      = no_cdb;
    cdb2      = no_cdb;
    repeat (3) @(posedge clock);
    #2;
    reset = 1'b0;

    // paired dispatch from tag 0, enough pairs to wrap the tail
    mark = errors;
    assert (rob_empty === 1'b1 && rob_full === 1'b0)
      else report_fail("empty and full after reset", 64'({rob_empty, rob_full}), 64'(2'b10));
    repeat (10)
    begin
      drive(random_op(), random_op(), no_cdb, no_cdb);
      drain(10);
    end
    end_test("tag order and wrap", mark);

    mark = errors;
    repeat (4) drive(random_op(), random_op(), no_cdb, no_cdb);
    drain(40);
    end_test("out of order completion", mark);

    // clean pair, mispredict in the next slot, mispredict at the head
    mark      = errors;
    dual_mark = dual_retires;
    misp_mark = misp_retires;
    base      = m_tail;
    repeat (3) drive(random_op(), random_op(), no_cdb, no_cdb);
    drive(no_dispatch, no_dispatch, result_for(base, 1'b0),
          result_for(rob_tag_t'(base + 1), 1'b0));
    drive(no_dispatch, no_dispatch, result_for(rob_tag_t'(base + 2), 1'b0),
          result_for(rob_tag_t'(base + 3), 1'b1));
    drive(no_dispatch, no_dispatch, result_for(rob_tag_t'(base + 4), 1'b1),
          result_for(rob_tag_t'(base + 5), 1'b0));
    drain(20);
    assert (dual_retires > dual_mark) else report_fail("dual retires", 64'(0), 64'(1));
    assert (misp_retires > misp_mark) else report_fail("mispredicted retires", 64'(0), 64'(1));
    end_test("dual retire and misprediction", mark);

    // 16 in use, then 15 in use, each followed by refused pairs
    mark = errors;
    repeat (8) drive(random_op(), random_op(), no_cdb, no_cdb);
    assert (rob_full === 1'b1) else report_fail("rob_full at 16", 64'(rob_full), 64'(1));
    repeat (3) drive(random_op(), random_op(), no_cdb, no_cdb);
    drain(40);
    repeat (7) drive(random_op(), random_op(), no_cdb, no_cdb);
    drive(no_dispatch, random_op(), no_cdb, no_cdb);
    assert (rob_full === 1'b1) else report_fail("rob_full at 15", 64'(rob_full), 64'(1));
    repeat (2) drive(random_op(), random_op(), no_cdb, no_cdb);
    drain(40);
    end_test("full buffer", mark);

    // results for empty slots first, then one tag on both buses
    mark = errors;
    base = m_tail;
    drive(no_dispatch, no_dispatch, result_for(base, 1'b0),
          result_for(rob_tag_t'(base + 1), 1'b0));
    drive(random_op(), random_op(), no_cdb, no_cdb);
    drive(no_dispatch, no_dispatch, result_for(base, 1'b0), result_for(base, 1'b1));
    drain(20);
    end_test("cdb conflicts", mark);

    repeat (2) drive(no_dispatch, no_dispatch, no_cdb, no_cdb);
    errors += UUT.u_asserts.failures;
    $display("summary: %0d errors, %0d dual retires, %0d mispredicted retires",
             errors, dual_retires, misp_retires);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* rob.f */
+incdir+common
common/rob_pkg.sv
rob_entry_file/rob_entry.sv
rob_entry_file/rob_entry_file.sv
design/rob_dispatch.sv
design/rob_retire.sv
design/rob_top.sv
verif/rob_asserts.sv
verif/rob_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the reorder buffer testbench with Verilator and run it
# the run passes only when the simulation output holds the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rob_tb -f rob.f -o rob_sim \
  || { echo "verilator build failed"; exit 1; }

sim_output="$(./obj_dir/rob_sim +verilator+error+limit+1000)"
echo "$sim_output"
echo "$sim_output" | grep -q "TESTS PASSED" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
